//--- logic/mem_fabric_pkg.sv
`default_nettype none

package mem_fabric_pkg;

  // ==================================================
  // Bus widths
  // ==================================================
  // Core side byte address
  localparam int ADDR_W = 32;
  // One full word per access, no strobes
  localparam int DATA_W = 32;
  // Debug module APB space, low bits of core address
  localparam int APB_ADDR_W = 13;
  // RAM word index from core address bits 13:2
  localparam int RAM_AW = 12;

  // ==================================================
  // Debug window
  // ==================================================
  // Byte range routed to APB while in debug mode
  localparam logic [ADDR_W-1:0] DEBUG_AREA_START = 32'h0000_0800;
  // Last byte, inclusive
  localparam logic [ADDR_W-1:0] DEBUG_AREA_END = 32'h0000_0FFF;

  // Data word shared by RAM, core ports and APB
  typedef logic [DATA_W-1:0] word_t;

endpackage

`default_nettype wire

//--- logic/apb_req_master.sv
`timescale 1ns/1ps
`default_nettype none

module apb_req_master #(
  parameter bit HAS_WRITE = 1'b1
) (
  input  logic                                clk,
  input  logic                                reset_n,
  // Request side, from router
  input  logic                                i_req,
  input  logic [mem_fabric_pkg::APB_ADDR_W-1:0] i_addr,
  input  logic                                i_write,
  input  mem_fabric_pkg::word_t               i_wdata,
  output logic                                o_busy,
  output logic                                o_done,
  output mem_fabric_pkg::word_t               o_rdata,
  // APB side, toward arbiter
  output logic                                o_psel,
  output logic                                o_penable,
  output logic [mem_fabric_pkg::APB_ADDR_W-1:0] o_paddr,
  output logic                                o_pwrite,
  output mem_fabric_pkg::word_t               o_pwdata,
  input  logic                                i_pready,
  input  mem_fabric_pkg::word_t               i_prdata
);

  import mem_fabric_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS
  } state_t;

  state_t                state_q;
  logic                  accept;
  logic                  finish;
  logic [APB_ADDR_W-1:0] addr_q;

  // New request only taken from idle
  assign accept = (state_q == ST_IDLE) && i_req;
  // Transfer ends on access cycle with pready
  assign finish = (state_q == ST_ACCESS) && i_pready;

  // ==================================================
  // State and completion
  // ==================================================
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state_q <= ST_IDLE;
      o_done  <= 1'b0;
    end
    else
    begin
      o_done <= finish;
      case (state_q)
        ST_IDLE:   if (accept) state_q <= ST_SETUP;
        ST_SETUP:  state_q <= ST_ACCESS;
        ST_ACCESS: if (i_pready) state_q <= ST_IDLE;
        default:   state_q <= ST_IDLE;
      endcase
    end
  end

  // Address and read data are payload
  always_ff @(posedge clk)
  begin
    if (accept)
      addr_q <= i_addr;
    if (finish)
      o_rdata <= i_prdata;
  end

  assign o_busy    = (state_q != ST_IDLE);
  assign o_psel    = (state_q != ST_IDLE);
  assign o_penable = (state_q == ST_ACCESS);
  assign o_paddr   = addr_q;

  // Write path only for the data side instance
  generate
    if (HAS_WRITE)
    begin : g_write
      logic  write_q;
      word_t wdata_q;

      always_ff @(posedge clk or negedge reset_n)
      begin
        if (!reset_n)
          write_q <= 1'b0;
        else if (accept)
          write_q <= i_write;
      end

      always_ff @(posedge clk)
      begin
        if (accept)
          wdata_q <= i_wdata;
      end

      assign o_pwrite = write_q;
      assign o_pwdata = wdata_q;
    end
    else
    begin : g_read_only
      assign o_pwrite = 1'b0;
      assign o_pwdata = '0;
    end
  endgenerate

  // Address held from setup until the transfer finishes
  a_paddr_stable: assert property (@(posedge clk) disable iff (!reset_n)
    (o_psel && !finish) |=> $stable(o_paddr));

endmodule

`default_nettype wire

//--- logic/apb_two_master_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module apb_two_master_arbiter (
  input  logic                                  clk,
  input  logic                                  reset_n,
  // Master 0, data side
  input  logic                                  i_m0_psel,
  input  logic                                  i_m0_penable,
  input  logic [mem_fabric_pkg::APB_ADDR_W-1:0] i_m0_paddr,
  input  logic                                  i_m0_pwrite,
  input  mem_fabric_pkg::word_t                 i_m0_pwdata,
  output logic                                  o_m0_pready,
  output mem_fabric_pkg::word_t                 o_m0_prdata,
  // Master 1, fetch side
  input  logic                                  i_m1_psel,
  input  logic                                  i_m1_penable,
  input  logic [mem_fabric_pkg::APB_ADDR_W-1:0] i_m1_paddr,
  input  logic                                  i_m1_pwrite,
  input  mem_fabric_pkg::word_t                 i_m1_pwdata,
  output logic                                  o_m1_pready,
  output mem_fabric_pkg::word_t                 o_m1_prdata,
  // External port
  output logic                                  o_psel,
  output logic                                  o_penable,
  output logic [mem_fabric_pkg::APB_ADDR_W-1:0] o_paddr,
  output logic                                  o_pwrite,
  output mem_fabric_pkg::word_t                 o_pwdata,
  input  logic                                  i_pready,
  input  mem_fabric_pkg::word_t                 i_prdata
);

  import mem_fabric_pkg::*;

  // High from the access phase until pready
  logic ext_active;
  // Registered owner of the bus, 1 means fetch master
  logic grant_m1_q;
  // Master driving the external bus this cycle
  logic sel_m1;

  // ==================================================
  // Grant
  // ==================================================
  // Idle bus picks a winner, data master on a tie
  assign sel_m1 = ext_active ? grant_m1_q : !i_m0_psel;

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      ext_active <= 1'b0;
      grant_m1_q <= 1'b0;
    end
    else if (!ext_active)
    begin
      // Setup cycle just shown, move to access
      if (i_m0_psel || i_m1_psel)
      begin
        ext_active <= 1'b1;
        grant_m1_q <= sel_m1;
      end
    end
    else if (i_pready)
      ext_active <= 1'b0;
  end

  // ==================================================
  // External bus
  // ==================================================
  // First grant cycle is always setup
  assign o_psel    = ext_active || i_m0_psel || i_m1_psel;
  assign o_penable = ext_active;
  assign o_paddr   = sel_m1 ? i_m1_paddr  : i_m0_paddr;
  assign o_pwrite  = sel_m1 ? i_m1_pwrite : i_m0_pwrite;
  assign o_pwdata  = sel_m1 ? i_m1_pwdata : i_m0_pwdata;

  // Response only to the owner, and only in its access phase
  assign o_m0_pready = ext_active && !grant_m1_q && i_m0_penable && i_pready;
  assign o_m1_pready = ext_active &&  grant_m1_q && i_m1_penable && i_pready;
  assign o_m0_prdata = !grant_m1_q ? i_prdata : '0;
  assign o_m1_prdata =  grant_m1_q ? i_prdata : '0;

  // Access phase always follows a setup cycle with psel
  a_penable_psel: assert property (@(posedge clk) disable iff (!reset_n)
    o_penable |-> (o_psel && $past(o_psel)));

  // Owner keeps its request up for the whole access phase
  a_owner_holds: assert property (@(posedge clk) disable iff (!reset_n)
    ext_active |-> (grant_m1_q ? i_m1_psel : i_m0_psel));

endmodule

`default_nettype wire

//--- logic/dual_port_ram.sv
`timescale 1ns/1ps
`default_nettype none

module dual_port_ram #(
  parameter int RAM_DEPTH = 4096
) (
  input  logic                              clk,
  // Port A, fetch, read only
  input  logic                              i_a_rd_en,
  input  logic [mem_fabric_pkg::RAM_AW-1:0] i_a_addr,
  output mem_fabric_pkg::word_t             o_a_rdata,
  // Port B, data, read or write
  input  logic                              i_b_rd_en,
  input  logic                              i_b_wr_en,
  input  logic [mem_fabric_pkg::RAM_AW-1:0] i_b_addr,
  input  mem_fabric_pkg::word_t             i_b_wdata,
  output mem_fabric_pkg::word_t             o_b_rdata
);

  import mem_fabric_pkg::*;

  word_t mem [RAM_DEPTH];

  // Registered read, data valid one cycle after enable
  always_ff @(posedge clk)
  begin
    if (i_a_rd_en)
      o_a_rdata <= mem[i_a_addr];
  end

  always_ff @(posedge clk)
  begin
    if (i_b_wr_en)
      mem[i_b_addr] <= i_b_wdata;
    else if (i_b_rd_en)
      o_b_rdata <= mem[i_b_addr];
  end

  // Router must never issue both on port B
  a_b_rd_wr: assert property (@(posedge clk) !(i_b_rd_en && i_b_wr_en));

endmodule

`default_nettype wire

//--- logic/fetch_router.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_router (
  input  logic                                  clk,
  input  logic                                  reset_n,
  input  logic                                  i_debug_mode,
  // Core fetch port
  input  logic                                  i_imem_rready,
  input  logic [mem_fabric_pkg::ADDR_W-1:0]     i_imem_addr,
  output logic                                  o_imem_rvalid,
  output mem_fabric_pkg::word_t                 o_imem_rdata,
  // RAM port A
  output logic                                  o_ram_rd_en,
  output logic [mem_fabric_pkg::RAM_AW-1:0]     o_ram_addr,
  input  mem_fabric_pkg::word_t                 i_ram_rdata,
  // Fetch APB master
  output logic                                  o_dbg_req,
  output logic [mem_fabric_pkg::APB_ADDR_W-1:0] o_dbg_addr,
  input  logic                                  i_dbg_busy,
  input  logic                                  i_dbg_done,
  input  mem_fabric_pkg::word_t                 i_dbg_rdata
);

  import mem_fabric_pkg::*;

  logic hit_dbg;
  logic ram_valid_q;

  // Debug window only counts in debug mode
  assign hit_dbg = i_debug_mode && (i_imem_addr >= DEBUG_AREA_START) &&
                   (i_imem_addr <= DEBUG_AREA_END);

  // RAM path accepts every cycle
  assign o_ram_rd_en = i_imem_rready && !hit_dbg;
  assign o_ram_addr  = i_imem_addr[RAM_AW+1:2];

  // One APB read per held fetch, nothing while in flight
  assign o_dbg_req  = i_imem_rready && hit_dbg && !i_dbg_busy && !i_dbg_done;
  assign o_dbg_addr = i_imem_addr[APB_ADDR_W-1:0];

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      ram_valid_q <= 1'b0;
    else
      ram_valid_q <= o_ram_rd_en;
  end

  // Merge both completions, data by which path finished
  assign o_imem_rvalid = ram_valid_q || i_dbg_done;
  assign o_imem_rdata  = i_dbg_done ? i_dbg_rdata : i_ram_rdata;

endmodule

`default_nettype wire

//--- logic/data_router.sv
`timescale 1ns/1ps
`default_nettype none

module data_router #(
  parameter logic [mem_fabric_pkg::ADDR_W-1:0] TOHOST_ADDR = 32'h8000_1000
) (
  input  logic                                  clk,
  input  logic                                  reset_n,
  input  logic                                  i_debug_mode,
  // Core data port
  input  logic                                  i_dmem_rready,
  input  logic                                  i_dmem_wvalid,
  input  logic [mem_fabric_pkg::ADDR_W-1:0]     i_dmem_addr,
  input  mem_fabric_pkg::word_t                 i_dmem_wdata,
  output logic                                  o_dmem_rvalid,
  output logic                                  o_dmem_wready,
  output mem_fabric_pkg::word_t                 o_dmem_rdata,
  // RAM port B
  output logic                                  o_ram_rd_en,
  output logic                                  o_ram_wr_en,
  output logic [mem_fabric_pkg::RAM_AW-1:0]     o_ram_addr,
  output mem_fabric_pkg::word_t                 o_ram_wdata,
  input  mem_fabric_pkg::word_t                 i_ram_rdata,
  // Data APB master
  output logic                                  o_dbg_req,
  output logic [mem_fabric_pkg::APB_ADDR_W-1:0] o_dbg_addr,
  output logic                                  o_dbg_write,
  output mem_fabric_pkg::word_t                 o_dbg_wdata,
  input  logic                                  i_dbg_busy,
  input  logic                                  i_dbg_done,
  input  mem_fabric_pkg::word_t                 i_dbg_rdata,
  // Test result
  output mem_fabric_pkg::word_t                 o_tohost
);

  import mem_fabric_pkg::*;

  logic hit_dbg;
  logic ram_rvalid_q;
  // Pending debug access is a write
  logic dbg_write_q;

  assign hit_dbg = i_debug_mode && (i_dmem_addr >= DEBUG_AREA_START) &&
                   (i_dmem_addr <= DEBUG_AREA_END);

  // ==================================================
  // RAM and APB steering
  // ==================================================
  // Write wins if both are raised, port B does one thing
  assign o_ram_wr_en = i_dmem_wvalid && !hit_dbg;
  assign o_ram_rd_en = i_dmem_rready && !i_dmem_wvalid && !hit_dbg;
  assign o_ram_addr  = i_dmem_addr[RAM_AW+1:2];
  assign o_ram_wdata = i_dmem_wdata;

  assign o_dbg_req   = hit_dbg && (i_dmem_rready || i_dmem_wvalid) &&
                       !i_dbg_busy && !i_dbg_done;
  assign o_dbg_addr  = i_dmem_addr[APB_ADDR_W-1:0];
  assign o_dbg_write = i_dmem_wvalid;
  assign o_dbg_wdata = i_dmem_wdata;

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      ram_rvalid_q <= 1'b0;
      dbg_write_q  <= 1'b0;
      o_tohost     <= '0;
    end
    else
    begin
      ram_rvalid_q <= o_ram_rd_en;
      if (o_dbg_req)
        dbg_write_q <= i_dmem_wvalid;
      // Test result lands with the RAM write
      if (o_ram_wr_en && (i_dmem_addr == TOHOST_ADDR))
        o_tohost <= i_dmem_wdata;
    end
  end

  // ==================================================
  // Completion merge
  // ==================================================
  // RAM write completes in the same cycle
  assign o_dmem_wready = o_ram_wr_en || (i_dbg_done && dbg_write_q);
  assign o_dmem_rvalid = ram_rvalid_q || (i_dbg_done && !dbg_write_q);
  assign o_dmem_rdata  = i_dbg_done ? i_dbg_rdata : i_ram_rdata;

endmodule

`default_nettype wire

//--- logic/mem_fabric_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_fabric_top #(
  parameter logic [mem_fabric_pkg::ADDR_W-1:0] TOHOST_ADDR = 32'h8000_1000,
  parameter int                                RAM_DEPTH   = 4096
) (
  input  logic                                  clk,
  input  logic                                  reset_n,
  input  logic                                  i_debug_mode,
  // Core fetch port
  input  logic                                  i_imem_rready,
  input  logic [mem_fabric_pkg::ADDR_W-1:0]     i_imem_addr,
  output logic                                  o_imem_rvalid,
  output mem_fabric_pkg::word_t                 o_imem_rdata,
  // Core data port
  input  logic                                  i_dmem_rready,
  input  logic                                  i_dmem_wvalid,
  input  logic [mem_fabric_pkg::ADDR_W-1:0]     i_dmem_addr,
  input  mem_fabric_pkg::word_t                 i_dmem_wdata,
  output logic                                  o_dmem_rvalid,
  output logic                                  o_dmem_wready,
  output mem_fabric_pkg::word_t                 o_dmem_rdata,
  output mem_fabric_pkg::word_t                 o_tohost,
  // External APB to debug module
  output logic [mem_fabric_pkg::APB_ADDR_W-1:0] o_apb_paddr,
  output logic                                  o_apb_psel,
  output logic                                  o_apb_penable,
  output logic                                  o_apb_pwrite,
  output mem_fabric_pkg::word_t                 o_apb_pwdata,
  input  logic                                  i_apb_pready,
  input  mem_fabric_pkg::word_t                 i_apb_prdata
);

  import mem_fabric_pkg::*;

  // RAM ports
  logic              ram_a_rd_en;
  logic [RAM_AW-1:0] ram_a_addr;
  word_t             ram_a_rdata;
  logic              ram_b_rd_en;
  logic              ram_b_wr_en;
  logic [RAM_AW-1:0] ram_b_addr;
  word_t             ram_b_wdata;
  word_t             ram_b_rdata;

  // Fetch side request and APB
  logic                  f_req;
  logic [APB_ADDR_W-1:0] f_addr;
  logic                  f_busy;
  logic                  f_done;
  word_t                 f_rdata;
  logic                  f_psel;
  logic                  f_penable;
  logic [APB_ADDR_W-1:0] f_paddr;
  logic                  f_pwrite;
  word_t                 f_pwdata;
  logic                  f_pready;
  word_t                 f_prdata;

  // Data side request and APB
  logic                  d_req;
  logic [APB_ADDR_W-1:0] d_addr;
  logic                  d_write;
  word_t                 d_wdata;
  logic                  d_busy;
  logic                  d_done;
  word_t                 d_rdata;
  logic                  d_psel;
  logic                  d_penable;
  logic [APB_ADDR_W-1:0] d_paddr;
  logic                  d_pwrite;
  word_t                 d_pwdata;
  logic                  d_pready;
  word_t                 d_prdata;

  // ==================================================
  // Routers
  // ==================================================
  fetch_router i_fetch_router (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_debug_mode  (i_debug_mode),
    .i_imem_rready (i_imem_rready),
    .i_imem_addr   (i_imem_addr),
    .o_imem_rvalid (o_imem_rvalid),
    .o_imem_rdata  (o_imem_rdata),
    .o_ram_rd_en   (ram_a_rd_en),
    .o_ram_addr    (ram_a_addr),
    .i_ram_rdata   (ram_a_rdata),
    .o_dbg_req     (f_req),
    .o_dbg_addr    (f_addr),
    .i_dbg_busy    (f_busy),
    .i_dbg_done    (f_done),
    .i_dbg_rdata   (f_rdata)
  );

  data_router #(
    .TOHOST_ADDR (TOHOST_ADDR)
  ) i_data_router (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_debug_mode  (i_debug_mode),
    .i_dmem_rready (i_dmem_rready),
    .i_dmem_wvalid (i_dmem_wvalid),
    .i_dmem_addr   (i_dmem_addr),
    .i_dmem_wdata  (i_dmem_wdata),
    .o_dmem_rvalid (o_dmem_rvalid),
    .o_dmem_wready (o_dmem_wready),
    .o_dmem_rdata  (o_dmem_rdata),
    .o_ram_rd_en   (ram_b_rd_en),
    .o_ram_wr_en   (ram_b_wr_en),
    .o_ram_addr    (ram_b_addr),
    .o_ram_wdata   (ram_b_wdata),
    .i_ram_rdata   (ram_b_rdata),
    .o_dbg_req     (d_req),
    .o_dbg_addr    (d_addr),
    .o_dbg_write   (d_write),
    .o_dbg_wdata   (d_wdata),
    .i_dbg_busy    (d_busy),
    .i_dbg_done    (d_done),
    .i_dbg_rdata   (d_rdata),
    .o_tohost      (o_tohost)
  );

  // ==================================================
  // APB masters and arbiter
  // ==================================================
  // Fetch master is read only
  apb_req_master #(
    .HAS_WRITE (1'b0)
  ) i_fetch_master (
    .clk       (clk),
    .reset_n   (reset_n),
    .i_req     (f_req),
    .i_addr    (f_addr),
    .i_write   (),
    .i_wdata   (),
    .o_busy    (f_busy),
    .o_done    (f_done),
    .o_rdata   (f_rdata),
    .o_psel    (f_psel),
    .o_penable (f_penable),
    .o_paddr   (f_paddr),
    .o_pwrite  (f_pwrite),
    .o_pwdata  (f_pwdata),
    .i_pready  (f_pready),
    .i_prdata  (f_prdata)
  );

  apb_req_master #(
    .HAS_WRITE (1'b1)
  ) i_data_master (
    .clk       (clk),
    .reset_n   (reset_n),
    .i_req     (d_req),
    .i_addr    (d_addr),
    .i_write   (d_write),
    .i_wdata   (d_wdata),
    .o_busy    (d_busy),
    .o_done    (d_done),
    .o_rdata   (d_rdata),
    .o_psel    (d_psel),
    .o_penable (d_penable),
    .o_paddr   (d_paddr),
    .o_pwrite  (d_pwrite),
    .o_pwdata  (d_pwdata),
    .i_pready  (d_pready),
    .i_prdata  (d_prdata)
  );

  // Data master on m0 so it wins a tie
  apb_two_master_arbiter i_apb_arbiter (
    .clk          (clk),
    .reset_n      (reset_n),
    .i_m0_psel    (d_psel),
    .i_m0_penable (d_penable),
    .i_m0_paddr   (d_paddr),
    .i_m0_pwrite  (d_pwrite),
    .i_m0_pwdata  (d_pwdata),
    .o_m0_pready  (d_pready),
    .o_m0_prdata  (d_prdata),
    .i_m1_psel    (f_psel),
    .i_m1_penable (f_penable),
    .i_m1_paddr   (f_paddr),
    .i_m1_pwrite  (f_pwrite),
    .i_m1_pwdata  (f_pwdata),
    .o_m1_pready  (f_pready),
    .o_m1_prdata  (f_prdata),
    .o_psel       (o_apb_psel),
    .o_penable    (o_apb_penable),
    .o_paddr      (o_apb_paddr),
    .o_pwrite     (o_apb_pwrite),
    .o_pwdata     (o_apb_pwdata),
    .i_pready     (i_apb_pready),
    .i_prdata     (i_apb_prdata)
  );

  // Shared memory, fetch on A and data on B
  dual_port_ram #(
    .RAM_DEPTH (RAM_DEPTH)
  ) i_dual_port_ram (
    .clk       (clk),
    .i_a_rd_en (ram_a_rd_en),
    .i_a_addr  (ram_a_addr),
    .o_a_rdata (ram_a_rdata),
    .i_b_rd_en (ram_b_rd_en),
    .i_b_wr_en (ram_b_wr_en),
    .i_b_addr  (ram_b_addr),
    .i_b_wdata (ram_b_wdata),
    .o_b_rdata (ram_b_rdata)
  );

endmodule

`default_nettype wire

//--- verif/mem_fabric_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_fabric_tb;

  import mem_fabric_pkg::*;

  localparam int          CLK_PERIOD     = 100;
  localparam int          TIMEOUT_CYCLES = 40;
  localparam int          N_ENTRIES      = 17;
  localparam logic [31:0] TOHOST_ADDR    = 32'h8000_1000;

  // Table operations
  localparam logic [1:0] OP_FETCH = 2'd0;
  localparam logic [1:0] OP_READ  = 2'd1;
  localparam logic [1:0] OP_WRITE = 2'd2;
  // Fetch at addr and data write at addr + 4 issued in the same cycle
  localparam logic [1:0] OP_BOTH  = 2'd3;

  typedef struct packed {
    logic [1:0]  op;
    logic        dbg;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] exp;
    logic [1:0]  n_apb;
  } entry_t;

  logic                  clk;
  logic                  reset_n;
  logic                  i_debug_mode;
  logic                  i_imem_rready;
  logic [ADDR_W-1:0]     i_imem_addr;
  logic                  o_imem_rvalid;
  word_t                 o_imem_rdata;
  logic                  i_dmem_rready;
  logic                  i_dmem_wvalid;
  logic [ADDR_W-1:0]     i_dmem_addr;
  word_t                 i_dmem_wdata;
  logic                  o_dmem_rvalid;
  logic                  o_dmem_wready;
  word_t                 o_dmem_rdata;
  word_t                 o_tohost;
  logic [APB_ADDR_W-1:0] o_apb_paddr;
  logic                  o_apb_psel;
  logic                  o_apb_penable;
  logic                  o_apb_pwrite;
  word_t                 o_apb_pwdata;
  logic                  i_apb_pready;
  word_t                 i_apb_prdata;

  entry_t                stim [N_ENTRIES];
  int                    errors;
  int                    checks;
  bit                    timed_out;
  word_t                 exp_tohost;

  // APB slave model state
  word_t                 model_mem [1 << APB_ADDR_W];
  logic [APB_ADDR_W-1:0] log_paddr [$];
  logic                  log_write [$];
  word_t                 log_wdata [$];
  logic [31:0]           rng_state;
  int                    wait_left;
  bit                    in_access;

  mem_fabric_top #(
    .TOHOST_ADDR (TOHOST_ADDR),
    .RAM_DEPTH   (4096)
  ) i_mem_fabric_top (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_debug_mode  (i_debug_mode),
    .i_imem_rready (i_imem_rready),
    .i_imem_addr   (i_imem_addr),
    .o_imem_rvalid (o_imem_rvalid),
    .o_imem_rdata  (o_imem_rdata),
    .i_dmem_rready (i_dmem_rready),
    .i_dmem_wvalid (i_dmem_wvalid),
    .i_dmem_addr   (i_dmem_addr),
    .i_dmem_wdata  (i_dmem_wdata),
    .o_dmem_rvalid (o_dmem_rvalid),
    .o_dmem_wready (o_dmem_wready),
    .o_dmem_rdata  (o_dmem_rdata),
    .o_tohost      (o_tohost),
    .o_apb_paddr   (o_apb_paddr),
    .o_apb_psel    (o_apb_psel),
    .o_apb_penable (o_apb_penable),
    .o_apb_pwrite  (o_apb_pwrite),
    .o_apb_pwdata  (o_apb_pwdata),
    .i_apb_pready  (i_apb_pready),
    .i_apb_prdata  (i_apb_prdata)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ==================================================
  // Helpers
  // ==================================================
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Debug module power-up word tagged with its own address
  function automatic word_t model_fill(input int unsigned a);
    return 32'hd000_0000 | a;
  endfunction

  function automatic bit in_debug_window(input logic dbg, input logic [31:0] a);
    return dbg && (a >= DEBUG_AREA_START) && (a <= DEBUG_AREA_END);
  endfunction

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("ERR %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  // ==================================================
  // APB slave model
  // ==================================================
  // Drives pready on the falling edge ahead of the completing edge
  always @(negedge clk)
  begin
    i_apb_pready = 1'b0;
    assert (!(o_apb_penable && !o_apb_psel))
    else
    begin
      errors++;
      $display("APB penable was high without psel at %0t", $time);
    end
    if (reset_n && o_apb_psel && o_apb_penable)
    begin
      // First access cycle picks 0 to 3 wait states
      if (!in_access)
      begin
        in_access = 1'b1;
        wait_left = next_random() % 4;
      end
      if (wait_left == 0)
      begin
        i_apb_pready = 1'b1;
        i_apb_prdata = model_mem[o_apb_paddr];
        in_access    = 1'b0;
        if (o_apb_pwrite)
          model_mem[o_apb_paddr] = o_apb_pwdata;
        log_paddr.push_back(o_apb_paddr);
        log_write.push_back(o_apb_pwrite);
        log_wdata.push_back(o_apb_pwdata);
        $display("APB %s paddr 0x%04h wdata 0x%08h rdata 0x%08h",
                 o_apb_pwrite ? "write" : "read ", o_apb_paddr, o_apb_pwdata,
                 i_apb_prdata);
      end
      else
        wait_left--;
    end
  end

  // ==================================================
  // Core-side driver
  // ==================================================
  // Starts and ends on a falling edge
  task automatic apply_entry(input entry_t e);
    bit          f_pend;
    bit          d_pend;
    bit          d_wr;
    bit          routed;
    int          cycles;
    int          f_cycles;
    int          d_cycles;
    int          base;
    int          n;
    word_t       f_got;
    word_t       d_got;
    logic [31:0] d_addr;

    d_wr     = (e.op == OP_WRITE) || (e.op == OP_BOTH);
    d_addr   = (e.op == OP_BOTH) ? e.addr + 32'd4 : e.addr;
    routed   = in_debug_window(e.dbg, e.addr);
    base     = log_paddr.size();
    f_pend   = (e.op == OP_FETCH) || (e.op == OP_BOTH);
    d_pend   = (e.op != OP_FETCH);
    f_cycles = 0;
    d_cycles = 0;
    f_got    = '0;
    d_got    = '0;

    i_debug_mode  = e.dbg;
    i_imem_rready = f_pend;
    i_imem_addr   = e.addr;
    i_dmem_rready = d_pend && !d_wr;
    i_dmem_wvalid = d_pend && d_wr;
    i_dmem_addr   = d_addr;
    i_dmem_wdata  = e.wdata;

    // RAM write is acknowledged in the cycle it is driven
    if (d_wr && !routed)
    begin
      #(CLK_PERIOD / 4);
      check_word("o_dmem_wready", o_dmem_wready, 1'b1);
    end

    cycles = 0;
    while ((f_pend || d_pend) && (cycles < TIMEOUT_CYCLES))
    begin
      // Sample in the high phase once the edge has settled
      @(posedge clk);
      #(CLK_PERIOD / 4);
      cycles++;
      if (f_pend && o_imem_rvalid)
      begin
        f_pend   = 1'b0;
        f_got    = o_imem_rdata;
        f_cycles = cycles;
      end
      if (d_pend && (d_wr ? o_dmem_wready : o_dmem_rvalid))
      begin
        d_pend   = 1'b0;
        d_got    = o_dmem_rdata;
        d_cycles = cycles;
      end
      // Request drops in the cycle of its completion
      @(negedge clk);
      if (!f_pend)
        i_imem_rready = 1'b0;
      if (!d_pend)
      begin
        i_dmem_rready = 1'b0;
        i_dmem_wvalid = 1'b0;
      end
    end

    if (f_pend || d_pend)
    begin
      timed_out     = 1'b1;
      i_imem_rready = 1'b0;
      i_dmem_rready = 1'b0;
      i_dmem_wvalid = 1'b0;
      $display("Timeout: access to 0x%08h not completed within %0d cycles",
               e.addr, TIMEOUT_CYCLES);
    end
    else
    begin
      if (f_cycles != 0)
        check_word("o_imem_rdata", f_got, e.exp);
      if (e.op == OP_READ)
        check_word("o_dmem_rdata", d_got, e.exp);
      // RAM path answers in the first cycle after the request edge
      if (!routed)
      begin
        checks++;
        assert ((f_cycles + d_cycles) == 1)
        else
        begin
          errors++;
          $display("RAM access to 0x%08h took %0d cycles instead of 1",
                   e.addr, f_cycles + d_cycles);
        end
      end
      if (d_wr && !routed && (d_addr == TOHOST_ADDR))
        exp_tohost = e.wdata;
      check_word("o_tohost", o_tohost, exp_tohost);

      n = log_paddr.size() - base;
      checks++;
      assert (n == e.n_apb)
      else
      begin
        errors++;
        $display("Access to 0x%08h made %0d APB transfers, expected %0d",
                 e.addr, n, e.n_apb);
      end
      if ((n == 1) && (e.n_apb == 1))
      begin
        check_word("o_apb_paddr", log_paddr[base], e.addr[APB_ADDR_W-1:0]);
        check_word("o_apb_pwrite", log_write[base], d_wr);
        if (d_wr)
          check_word("o_apb_pwdata", log_wdata[base], e.wdata);
      end
      // Data master wins the tie and goes first
      if ((n == 2) && (e.n_apb == 2))
      begin
        check_word("o_apb_paddr", log_paddr[base], d_addr[APB_ADDR_W-1:0]);
        check_word("o_apb_pwrite", log_write[base], 1'b1);
        check_word("o_apb_pwdata", log_wdata[base], e.wdata);
        check_word("o_apb_paddr", log_paddr[base + 1], e.addr[APB_ADDR_W-1:0]);
        check_word("o_apb_pwrite", log_write[base + 1], 1'b0);
      end
    end
  endtask

  // ==================================================
  // Main sequence
  // ==================================================
  initial
  begin
    clk           = 1'b0;
    reset_n       = 1'b0;
    i_debug_mode  = 1'b0;
    i_imem_rready = 1'b0;
    i_imem_addr   = '0;
    i_dmem_rready = 1'b0;
    i_dmem_wvalid = 1'b0;
    i_dmem_addr   = '0;
    i_dmem_wdata  = '0;
    i_apb_pready  = 1'b0;
    i_apb_prdata  = '0;
    errors        = 0;
    checks        = 0;
    timed_out     = 1'b0;
    exp_tohost    = '0;
    rng_state     = 32'h7a52dcf1;
    wait_left     = 0;
    in_access     = 1'b0;
    for (int a = 0; a < (1 << APB_ADDR_W); a++)
      model_mem[a] = model_fill(a);

    // op, debug, address, write data, expected data, APB transfers
    stim[0]  = '{OP_WRITE, 1'b0, 32'h0000_0100, 32'h1234_5678, 32'h0, 2'd0};
    stim[1]  = '{OP_WRITE, 1'b0, 32'h0000_0104, 32'h9abc_def0, 32'h0, 2'd0};
    stim[2]  = '{OP_READ,  1'b0, 32'h0000_0100, 32'h0, 32'h1234_5678, 2'd0};
    stim[3]  = '{OP_READ,  1'b0, 32'h0000_0104, 32'h0, 32'h9abc_def0, 2'd0};
    stim[4]  = '{OP_FETCH, 1'b0, 32'h0000_0100, 32'h0, 32'h1234_5678, 2'd0};
    stim[5]  = '{OP_FETCH, 1'b0, 32'h0000_0104, 32'h0, 32'h9abc_def0, 2'd0};
    // Window address outside debug mode lands in RAM
    stim[6]  = '{OP_WRITE, 1'b0, 32'h0000_0800, 32'h1111_0800, 32'h0, 2'd0};
    stim[7]  = '{OP_FETCH, 1'b1, 32'h0000_0800, 32'h0, 32'hd000_0800, 2'd1};
    stim[8]  = '{OP_FETCH, 1'b0, 32'h0000_0800, 32'h0, 32'h1111_0800, 2'd0};
    stim[9]  = '{OP_WRITE, 1'b1, 32'h0000_0840, 32'hcafe_0001, 32'h0, 2'd1};
    stim[10] = '{OP_READ,  1'b1, 32'h0000_0840, 32'h0, 32'hcafe_0001, 2'd1};
    stim[11] = '{OP_WRITE, 1'b0, 32'h8000_1000, 32'h0000_0001, 32'h0, 2'd0};
    stim[12] = '{OP_WRITE, 1'b0, 32'h0000_0200, 32'hdead_beef, 32'h0, 2'd0};
    stim[13] = '{OP_BOTH,  1'b1, 32'h0000_0900, 32'h5555_aaaa, 32'hd000_0900, 2'd2};
    stim[14] = '{OP_READ,  1'b1, 32'h0000_0904, 32'h0, 32'h5555_aaaa, 2'd1};
    stim[15] = '{OP_READ,  1'b0, 32'h0000_0200, 32'h0, 32'hdead_beef, 2'd0};
    // Debug mode but outside the window
    stim[16] = '{OP_READ,  1'b1, 32'h0000_0100, 32'h0, 32'h1234_5678, 2'd0};

    repeat (5) @(posedge clk);
    @(negedge clk);
    // Idle outputs while held in reset
    check_word("o_apb_psel", o_apb_psel, 1'b0);
    check_word("o_apb_penable", o_apb_penable, 1'b0);
    check_word("o_imem_rvalid", o_imem_rvalid, 1'b0);
    check_word("o_dmem_rvalid", o_dmem_rvalid, 1'b0);
    check_word("o_dmem_wready", o_dmem_wready, 1'b0);
    check_word("o_tohost", o_tohost, 32'h0);
    reset_n = 1'b1;
    @(negedge clk);

    for (int i = 0; (i < N_ENTRIES) && !timed_out; i++)
    begin
      apply_entry(stim[i]);
      @(negedge clk);
    end

    $display("Checks: %0d  errors: %0d  APB transfers: %0d  timeouts: %0d",
             checks, errors, log_paddr.size(), timed_out);
    if ((errors == 0) && !timed_out)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
logic/mem_fabric_pkg.sv
logic/apb_req_master.sv
logic/apb_two_master_arbiter.sv
logic/dual_port_ram.sv
logic/fetch_router.sv
logic/data_router.sv
logic/mem_fabric_top.sv
verif/mem_fabric_tb.sv
